//--- trace_pkg.sv
/*
 * Shared trace encoder types: data word widths, RISC-V opcodes,
 * instruction format enum, access mask bits, retirement and record structs
 */
package trace_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_mask_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // Cycle stamp field, wide enough for the default counter
  localparam int unsigned CYCLE_FIELD_WIDTH = 32;
  typedef logic [CYCLE_FIELD_WIDTH-1:0] cycle_t;

  typedef enum logic [3:0] {
    R          = 4'd0,
    I          = 4'd1,
    I_SHIFT    = 4'd2,
    I_JALR     = 4'd3,
    LOAD       = 4'd4,
    S          = 4'd5,
    B          = 4'd6,
    U          = 4'd7,
    J          = 4'd8,
    CSR        = 4'd9,
    SYSTEM     = 4'd10,
    FENCE      = 4'd11,
    COMPRESSED = 4'd12,
    ILLEGAL    = 4'd13
  } insn_format_e;

  // Bit 2 stands for rs3, never set by RV32I/M
  typedef logic [4:0] access_mask_t;
  localparam access_mask_t ACC_RS1 = 5'b00001;
  localparam access_mask_t ACC_RS2 = 5'b00010;
  localparam access_mask_t ACC_RD  = 5'b01000;
  localparam access_mask_t ACC_MEM = 5'b10000;

  // Major opcodes of the 32-bit encodings
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  typedef struct packed {
    insn_t      insn;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rs3_addr;
    xlen_t      rs1_rdata;
    xlen_t      rs2_rdata;
    xlen_t      rs3_rdata;
    reg_addr_t  rd_addr;
    xlen_t      rd_wdata;
    xlen_t      pc_rdata;
    xlen_t      pc_wdata;
    xlen_t      mem_addr;
    byte_mask_t mem_rmask;
    byte_mask_t mem_wmask;
    xlen_t      mem_rdata;
    xlen_t      mem_wdata;
  } rvfi_retire_t;

  typedef struct packed {
    insn_format_e format;
    access_mask_t access;
    logic         compressed;
  } decode_info_t;

  typedef struct packed {
    cycle_t       cycle;
    xlen_t        pc;
    insn_t        insn;
    insn_format_e format;
    access_mask_t access;
    xlen_t        imm;
    xlen_t        target;
    reg_addr_t    rs1_addr;
    xlen_t        rs1_rdata;
    reg_addr_t    rs2_addr;
    xlen_t        rs2_rdata;
    reg_addr_t    rd_addr;
    xlen_t        rd_wdata;
    xlen_t        mem_addr;
    logic         mem_load;
    logic         mem_store;
    xlen_t        mem_data;
  } trace_record_t;

endpackage

//--- insn_format_decoder.sv
/*
 * Instruction format classifier for RV32I and RV32M, with the set of
 * registers and memory each format touches
 */
`timescale 1ns/1ps

module insn_format_decoder (
  input  trace_pkg::insn_t        insn,
  output trace_pkg::decode_info_t info
);

  trace_pkg::opcode_t      opcode;
  trace_pkg::funct3_t      funct3;
  trace_pkg::funct7_t      funct7;
  trace_pkg::insn_format_e format;
  trace_pkg::access_mask_t access;
  logic                    compressed;
  logic                    system_ok;

  assign opcode     = insn[6:0];
  assign funct3     = insn[14:12];
  assign funct7     = insn[31:25];
  assign compressed = (insn[1:0] != 2'b11);

  // Operand-free privileged ops: ecall, ebreak, wfi, mret, dret
  always_comb begin
    system_ok = 1'b0;
    if (insn[19:7] == 13'h0) begin
      case (insn[31:20])
        12'h000, 12'h001, 12'h105, 12'h302, 12'h7b2: system_ok = 1'b1;
        default: system_ok = 1'b0;
      endcase
    end
  end

  always_comb begin
    format = trace_pkg::ILLEGAL;
    if (compressed) begin
      format = trace_pkg::COMPRESSED;
    end else begin
      case (opcode)
        trace_pkg::OPC_LUI, trace_pkg::OPC_AUIPC: begin
          format = trace_pkg::U;
        end
        trace_pkg::OPC_JAL: begin
          format = trace_pkg::J;
        end
        trace_pkg::OPC_JALR: begin
          if (funct3 == 3'b000) begin
            format = trace_pkg::I_JALR;
          end
        end
        trace_pkg::OPC_BRANCH: begin
          // funct3 010 and 011 are unassigned
          if (funct3[2:1] != 2'b01) begin
            format = trace_pkg::B;
          end
        end
        trace_pkg::OPC_LOAD: begin
          // lb, lh, lw, lbu, lhu
          case (funct3)
            3'b000, 3'b001, 3'b010, 3'b100, 3'b101: format = trace_pkg::LOAD;
            default: format = trace_pkg::ILLEGAL;
          endcase
        end
        trace_pkg::OPC_STORE: begin
          if (!funct3[2] && funct3[1:0] != 2'b11) begin
            format = trace_pkg::S;
          end
        end
        trace_pkg::OPC_OP_IMM: begin
          if (funct3 == 3'b001) begin
            if (funct7 == 7'b0000000) begin
              format = trace_pkg::I_SHIFT;
            end
          end else if (funct3 == 3'b101) begin
            // srli or srai
            if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
              format = trace_pkg::I_SHIFT;
            end
          end else begin
            format = trace_pkg::I;
          end
        end
        trace_pkg::OPC_OP: begin
          // Base ALU ops and the RV32M multiply/divide group
          if (funct7 == 7'b0000000 || funct7 == 7'b0000001) begin
            format = trace_pkg::R;
          end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
            format = trace_pkg::R;
          end
        end
        trace_pkg::OPC_MISC_MEM: begin
          // fence and fence.i
          if (funct3 == 3'b000 || funct3 == 3'b001) begin
            format = trace_pkg::FENCE;
          end
        end
        trace_pkg::OPC_SYSTEM: begin
          if (funct3 == 3'b000) begin
            if (system_ok) begin
              format = trace_pkg::SYSTEM;
            end
          end else if (funct3 != 3'b100) begin
            format = trace_pkg::CSR;
          end
        end
        default: begin
          format = trace_pkg::ILLEGAL;
        end
      endcase
    end
  end

  always_comb begin
    case (format)
      trace_pkg::R: begin
        access = trace_pkg::ACC_RS1 | trace_pkg::ACC_RS2 | trace_pkg::ACC_RD;
      end
      trace_pkg::I, trace_pkg::I_SHIFT, trace_pkg::I_JALR: begin
        access = trace_pkg::ACC_RS1 | trace_pkg::ACC_RD;
      end
      trace_pkg::LOAD: begin
        access = trace_pkg::ACC_RS1 | trace_pkg::ACC_RD | trace_pkg::ACC_MEM;
      end
      trace_pkg::S: begin
        access = trace_pkg::ACC_RS1 | trace_pkg::ACC_RS2 | trace_pkg::ACC_MEM;
      end
      trace_pkg::B: begin
        access = trace_pkg::ACC_RS1 | trace_pkg::ACC_RS2;
      end
      trace_pkg::U, trace_pkg::J: begin
        access = trace_pkg::ACC_RD;
      end
      trace_pkg::CSR: begin
        // Immediate variants take a uimm in place of rs1
        access = funct3[2] ? trace_pkg::ACC_RD : (trace_pkg::ACC_RD | trace_pkg::ACC_RS1);
      end
      default: begin
        access = '0;
      end
    endcase
  end

  assign info.format     = format;
  assign info.access     = access;
  assign info.compressed = compressed;

  // Format and mask tables must agree on what carries no operands
  always_comb begin
    assert final ((compressed == (format == trace_pkg::COMPRESSED)) &&
                  ((format != trace_pkg::ILLEGAL && format != trace_pkg::COMPRESSED) ||
                   access == '0))
      else $error("decoder: mask %b reported for format %s", access, format.name());
  end

endmodule

//--- insn_imm_extract.sv
/*
 * Sign-extended immediate per instruction format and the
 * PC-relative target of branches and JAL
 */
`timescale 1ns/1ps

module insn_imm_extract (
  input  trace_pkg::insn_t        insn,
  input  trace_pkg::xlen_t        pc,
  input  trace_pkg::insn_format_e format,
  output trace_pkg::xlen_t        imm,
  output trace_pkg::xlen_t        target
);

  trace_pkg::xlen_t imm_i;
  trace_pkg::xlen_t imm_shamt;
  trace_pkg::xlen_t imm_s;
  trace_pkg::xlen_t imm_b;
  trace_pkg::xlen_t imm_u;
  trace_pkg::xlen_t imm_j;
  trace_pkg::xlen_t imm_csr;
  logic             pc_relative;

  assign imm_i     = {{20{insn[31]}}, insn[31:20]};
  assign imm_shamt = {27'b0, insn[24:20]};
  assign imm_s     = {{20{insn[31]}}, insn[31:25], insn[11:7]};

  // Branch offsets are in halfwords, bit 0 is implicit
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  // uimm field of csrr*i sits where rs1 would be
  assign imm_csr = {27'b0, insn[19:15]};

  always_comb begin
    case (format)
      trace_pkg::I, trace_pkg::I_JALR, trace_pkg::LOAD: begin
        imm = imm_i;
      end
      trace_pkg::I_SHIFT: begin
        imm = imm_shamt;
      end
      trace_pkg::S: begin
        imm = imm_s;
      end
      trace_pkg::B: begin
        imm = imm_b;
      end
      trace_pkg::U: begin
        imm = imm_u;
      end
      trace_pkg::J: begin
        imm = imm_j;
      end
      trace_pkg::CSR: begin
        imm = imm_csr;
      end
      default: begin
        imm = '0;
      end
    endcase
  end

  // JALR depends on rs1 and gets no target here
  assign pc_relative = (format == trace_pkg::B) || (format == trace_pkg::J);
  assign target      = pc_relative ? (pc + imm) : '0;

endmodule

//--- trace_record_stage.sv
/*
 * Cycle counter and registered trace record with operand gating
 * by access mask and load/store classification
 */
`timescale 1ns/1ps

module trace_record_stage #(
  parameter int unsigned cycle_width = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rvfi_valid,
  input  logic                     enable,
  input  trace_pkg::rvfi_retire_t  rvfi,
  input  trace_pkg::decode_info_t  info,
  input  trace_pkg::xlen_t         imm,
  input  trace_pkg::xlen_t         target,
  output logic                     trace_valid,
  output trace_pkg::trace_record_t trace
);

  logic [cycle_width-1:0]   cycle_q;
  logic                     capture;
  logic                     mem_access;
  logic                     mem_load;
  logic                     mem_store;
  logic                     valid_q;
  trace_pkg::trace_record_t record_d;
  trace_pkg::trace_record_t record_q;

  assign capture = rvfi_valid & enable;

  // Free-running edge count since reset release, wraps at its width
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  assign mem_access = |(info.access & trace_pkg::ACC_MEM);
  assign mem_load   = mem_access && (rvfi.mem_rmask != '0);
  assign mem_store  = mem_access && (rvfi.mem_wmask != '0);

  always_comb begin
    record_d        = '0;
    record_d.cycle  = trace_pkg::cycle_t'(cycle_q);
    record_d.pc     = rvfi.pc_rdata;
    record_d.insn   = info.compressed ? {16'h0, rvfi.insn[15:0]} : rvfi.insn;
    record_d.format = info.format;
    record_d.access = info.access;
    record_d.imm    = imm;
    record_d.target = target;
    if (|(info.access & trace_pkg::ACC_RS1)) begin
      record_d.rs1_addr  = rvfi.rs1_addr;
      record_d.rs1_rdata = rvfi.rs1_rdata;
    end
    if (|(info.access & trace_pkg::ACC_RS2)) begin
      record_d.rs2_addr  = rvfi.rs2_addr;
      record_d.rs2_rdata = rvfi.rs2_rdata;
    end
    if (|(info.access & trace_pkg::ACC_RD)) begin
      record_d.rd_addr  = rvfi.rd_addr;
      record_d.rd_wdata = rvfi.rd_wdata;
    end
    if (mem_access) begin
      record_d.mem_addr  = rvfi.mem_addr;
      record_d.mem_load  = mem_load;
      record_d.mem_store = mem_store;
      // A load reports what came back, a store what went out
      if (mem_load) begin
        record_d.mem_data = rvfi.mem_rdata;
      end else if (mem_store) begin
        record_d.mem_data = rvfi.mem_wdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      record_q <= '0;
    end else begin
      valid_q <= capture;
      if (capture) begin
        record_q <= record_d;
      end
    end
  end

  assign trace_valid = valid_q;
  assign trace       = record_q;

  // Two pulses in a row need a retirement at both capturing edges
  back_to_back_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid && $past(trace_valid) |-> $past(rvfi_valid) && $past(rvfi_valid, 2))
    else $error("record stage: consecutive trace pulses without retirements");

endmodule

//--- rvfi_tracer.sv
/*
 * Retirement trace encoder top level
 * Decoder and immediate extractor feed the registered record stage
 */
`timescale 1ns/1ps

module rvfi_tracer #(
  parameter int unsigned cycle_width = 32
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rvfi_valid,
  input  logic                     enable,
  input  trace_pkg::rvfi_retire_t  rvfi,
  output logic                     trace_valid,
  output trace_pkg::trace_record_t trace
);

  trace_pkg::decode_info_t info;
  trace_pkg::xlen_t        imm;
  trace_pkg::xlen_t        target;

  insn_format_decoder u_decoder (
    .insn (rvfi.insn),
    .info (info)
  );

  insn_imm_extract u_imm_extract (
    .insn   (rvfi.insn),
    .pc     (rvfi.pc_rdata),
    .format (info.format),
    .imm    (imm),
    .target (target)
  );

  trace_record_stage #(
    .cycle_width (cycle_width)
  ) u_record_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rvfi_valid  (rvfi_valid),
    .enable      (enable),
    .rvfi        (rvfi),
    .info        (info),
    .imm         (imm),
    .target      (target),
    .trace_valid (trace_valid),
    .trace       (trace)
  );

endmodule

//--- trace_checker.sv
/*
 * Trace checker: counts edges since reset, queues expected records
 * on each captured retirement and compares every trace pulse
 */
`timescale 1ns/1ps

module trace_checker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rvfi_valid,
  input  logic                     enable,
  input  trace_pkg::trace_record_t expected,
  input  logic                     trace_valid,
  input  trace_pkg::trace_record_t trace,
  output int                       checks,
  output int                       value_errors,
  output int                       pulse_errors,
  output logic                     busy
);

  trace_pkg::trace_record_t pending [$];
  trace_pkg::trace_record_t queued;
  trace_pkg::trace_record_t want;
  trace_pkg::cycle_t        edges;
  logic                     seen_capture;

  initial begin
    checks       = 0;
    value_errors = 0;
    pulse_errors = 0;
    busy         = 1'b0;
    edges        = '0;
    seen_capture = 1'b0;
  end

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_record(input trace_pkg::trace_record_t rec);
    compare_field("cycle", trace.cycle, rec.cycle);
    compare_field("pc", trace.pc, rec.pc);
    compare_field("insn", trace.insn, rec.insn);
    compare_field("format", trace.format, rec.format);
    compare_field("access", trace.access, rec.access);
    compare_field("imm", trace.imm, rec.imm);
    compare_field("target", trace.target, rec.target);
    compare_field("rs1_addr", trace.rs1_addr, rec.rs1_addr);
    compare_field("rs1_rdata", trace.rs1_rdata, rec.rs1_rdata);
    compare_field("rs2_addr", trace.rs2_addr, rec.rs2_addr);
    compare_field("rs2_rdata", trace.rs2_rdata, rec.rs2_rdata);
    compare_field("rd_addr", trace.rd_addr, rec.rd_addr);
    compare_field("rd_wdata", trace.rd_wdata, rec.rd_wdata);
    compare_field("mem_addr", trace.mem_addr, rec.mem_addr);
    compare_field("mem_load", trace.mem_load, rec.mem_load);
    compare_field("mem_store", trace.mem_store, rec.mem_store);
    compare_field("mem_data", trace.mem_data, rec.mem_data);
  endtask

  // Stamp is the edge count before the capturing edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edges = '0;
    end else begin
      if (rvfi_valid && enable) begin
        queued       = expected;
        queued.cycle = edges;
        pending.push_back(queued);
        seen_capture = 1'b1;
      end
      edges = edges + 1'b1;
    end
    busy = (pending.size() != 0);
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (!seen_capture && (trace_valid !== 1'b0 || trace !== '0)) begin
      $display("FAIL %0t: trace not idle during or right after reset", $time);
      value_errors++;
    end
    if (trace_valid) begin
      if (pending.size() == 0) begin
        $display("Unexpected trace pulse at %0t without a retirement", $time);
        pulse_errors++;
      end else begin
        want = pending.pop_front();
        compare_record(want);
        checks++;
      end
    end else if (pending.size() != 0) begin
      $display("A captured retirement gave no trace pulse by %0t", $time);
      pulse_errors++;
      want = pending.pop_front();
    end
    busy = (pending.size() != 0);
  end

endmodule

//--- tb_rvfi_tracer.sv
/*
 * Retirement trace encoder testbench with clock, reset,
 * vector file reading, falling-edge stimulus and final report
 */
`timescale 1ns/1ps

module tb_rvfi_tracer;

  localparam int drain_timeout = 20;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     rvfi_valid;
  logic                     enable;
  trace_pkg::rvfi_retire_t  rvfi;
  logic                     trace_valid;
  trace_pkg::trace_record_t trace;
  trace_pkg::trace_record_t expected;
  int                       checks;
  int                       value_errors;
  int                       pulse_errors;
  int                       timeouts;
  logic                     busy;
  integer                   seed;
  integer                   fd;
  integer                   n;
  int                       wait_cycles;
  string                    line;
  logic [31:0]              col [0:19];

  rvfi_tracer #(
    .cycle_width (32)
  ) uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rvfi_valid  (rvfi_valid),
    .enable      (enable),
    .rvfi        (rvfi),
    .trace_valid (trace_valid),
    .trace       (trace)
  );

  trace_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvfi_valid   (rvfi_valid),
    .enable       (enable),
    .expected     (expected),
    .trace_valid  (trace_valid),
    .trace        (trace),
    .checks       (checks),
    .value_errors (value_errors),
    .pulse_errors (pulse_errors),
    .busy         (busy)
  );

  always #50 clk_i = ~clk_i;

  // Record that the current retirement should produce
  function automatic trace_pkg::trace_record_t expected_record();
    trace_pkg::trace_record_t rec;
    logic [4:0]               acc;
    rec        = '0;
    acc        = col[17][4:0];
    rec.pc     = rvfi.pc_rdata;
    rec.format = trace_pkg::insn_format_e'(col[16][3:0]);
    rec.insn   = (rec.format == trace_pkg::COMPRESSED) ? {16'h0, rvfi.insn[15:0]} : rvfi.insn;
    rec.access = acc;
    rec.imm    = col[18];
    rec.target = col[19];
    if (acc[0]) begin
      rec.rs1_addr  = rvfi.rs1_addr;
      rec.rs1_rdata = rvfi.rs1_rdata;
    end
    if (acc[1]) begin
      rec.rs2_addr  = rvfi.rs2_addr;
      rec.rs2_rdata = rvfi.rs2_rdata;
    end
    if (acc[3]) begin
      rec.rd_addr  = rvfi.rd_addr;
      rec.rd_wdata = rvfi.rd_wdata;
    end
    if (acc[4]) begin
      rec.mem_addr  = rvfi.mem_addr;
      rec.mem_load  = (rvfi.mem_rmask != 4'h0);
      rec.mem_store = (rvfi.mem_wmask != 4'h0);
      if (rec.mem_load) begin
        rec.mem_data = rvfi.mem_rdata;
      end else if (rec.mem_store) begin
        rec.mem_data = rvfi.mem_wdata;
      end
    end
    return rec;
  endfunction

  // Fill column set means data words come from the random stream
  task automatic drive_vector();
    logic fill;
    fill            = col[2][0];
    rvfi_valid      = col[0][0];
    enable          = col[1][0];
    rvfi            = '0;
    rvfi.insn       = col[3];
    rvfi.pc_rdata   = col[4];
    rvfi.pc_wdata   = col[4] + 32'd4;
    rvfi.rs1_addr   = col[5][4:0];
    rvfi.rs1_rdata  = fill ? $random(seed) : col[6];
    rvfi.rs2_addr   = col[7][4:0];
    rvfi.rs2_rdata  = fill ? $random(seed) : col[8];
    rvfi.rs3_addr   = 5'($random(seed));
    rvfi.rs3_rdata  = $random(seed);
    rvfi.rd_addr    = col[9][4:0];
    rvfi.rd_wdata   = fill ? $random(seed) : col[10];
    rvfi.mem_addr   = col[11];
    rvfi.mem_rmask  = col[12][3:0];
    rvfi.mem_wmask  = col[13][3:0];
    rvfi.mem_rdata  = fill ? $random(seed) : col[14];
    rvfi.mem_wdata  = fill ? $random(seed) : col[15];
    expected        = expected_record();
  endtask

  initial begin
    seed        = 86940;
    timeouts    = 0;
    wait_cycles = 0;
    rst_ni      = 1'b0;
    rvfi_valid  = 1'b0;
    enable      = 1'b0;
    rvfi        = '0;
    expected    = '0;
    fd = $fopen("trace_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file trace_vectors.txt");
      $display("Some tests failed");
    end else begin
      repeat (3) @(negedge clk_i);
      rst_ni = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                      col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                      col[14], col[15], col[16], col[17], col[18], col[19]);
          if (n == 20) begin
            @(negedge clk_i);
            drive_vector();
          end
        end
      end
      $fclose(fd);
      @(negedge clk_i);
      rvfi_valid = 1'b0;
      enable     = 1'b0;
      // Let the last pulses reach the checker
      do begin
        @(posedge clk_i);
        wait_cycles++;
      end while (busy && wait_cycles < drain_timeout);
      if (busy) begin
        $display("Timed out waiting for the last trace pulses");
        timeouts++;
      end
      @(negedge clk_i);
      @(negedge clk_i);
      $display("Checks: %0d, value errors: %0d, pulse errors: %0d, timeouts: %0d",
               checks, value_errors, pulse_errors, timeouts);
      if (value_errors == 0 && pulse_errors == 0 && timeouts == 0 && checks > 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
    end
    $finish;
  end

endmodule

//--- trace_vectors.txt
# valid enable fill insn pc rs1 rs1_data rs2 rs2_data rd rd_data mem_addr rmask wmask
# mem_rdata mem_wdata, then expected format access imm target (all hex, fill=1 randomizes data)
1 1 1 002081B3 1000 01 0 02 0 03 0 3000 F 0 0 0 0 0B 0 0
1 1 1 027302B3 1004 06 0 07 0 05 0 0 0 0 0 0 0 0B 0 0
1 1 1 FFB00093 1008 00 0 1F 0 01 0 0 0 0 0 0 1 09 FFFFFFFB 0
1 1 0 06408113 100C 01 FFFFFFFB 00 0 02 5F 0 0 0 0 0 1 09 64 0
1 1 1 4071D213 1010 03 0 00 0 04 0 0 0 0 0 0 2 09 7 0
1 1 1 FF8280E7 1014 05 0 00 0 01 0 0 0 0 0 0 3 09 FFFFFFF8 0
1 1 0 00C12303 2000 02 1FF0 00 0 06 55AA1234 1FFC F 0 55AA1234 0 4 19 C 0
1 1 1 FFF10383 2004 02 0 00 0 07 0 1FFF 1 0 0 0 4 19 FFFFFFFF 0
1 1 0 FE612E23 2008 02 2000 06 CAFEF00D 00 0 1FFC 0 F 0 CAFEF00D 5 13 FFFFFFFC 0
1 1 1 00208863 200C 01 0 02 0 00 0 0 0 0 0 0 6 03 10 201C
1 1 1 FE209CE3 2010 01 0 02 0 00 0 0 0 0 0 0 6 03 FFFFFFF8 2008
1 1 1 12345537 2014 00 0 00 0 0A 0 0 0 0 0 0 7 08 12345000 0
1 1 1 FFFFF597 2018 00 0 00 0 0B 0 0 0 0 0 0 7 08 FFFFF000 0
1 1 1 001000EF 201C 00 0 00 0 01 0 0 0 0 0 0 8 08 800 281C
1 1 1 FFDFF06F 2820 00 0 00 0 00 0 0 0 0 0 0 8 08 FFFFFFFC 281C
1 1 1 300312F3 2824 06 0 00 0 05 0 0 0 0 0 0 9 09 6 0
1 1 1 3002E3F3 2828 05 0 00 0 07 0 0 0 0 0 0 9 08 5 0
1 1 1 00000073 282C 00 0 00 0 00 0 0 0 0 0 0 A 00 0 0
1 1 1 0FF0000F 2830 00 0 00 0 00 0 0 0 0 0 0 B 00 0 0
1 1 1 ABCD0505 2834 0A 0 00 0 0A 0 0 0 0 0 0 C 00 0 0
1 1 1 00C13303 2836 02 0 00 0 06 0 1FFC F 0 0 0 D 00 0 0
1 0 1 002081B3 283A 01 0 02 0 03 0 0 0 0 0 0 0 0B 0 0
0 1 1 00000013 283E 00 0 00 0 00 0 0 0 0 0 0 1 09 0 0
1 1 1 002081B3 283E 01 0 02 0 03 0 0 0 0 0 0 0 0B 0 0

//--- src.f
trace_pkg.sv
insn_format_decoder.sv
insn_imm_extract.sv
trace_record_stage.sv
rvfi_tracer.sv
trace_checker.sv
tb_rvfi_tracer.sv

//--- Bender.yml
package:
  name: rvfi_tracer

sources:
  - trace_pkg.sv
  - insn_format_decoder.sv
  - insn_imm_extract.sv
  - trace_record_stage.sv
  - rvfi_tracer.sv
  - target: test
    files:
      - trace_checker.sv
      - tb_rvfi_tracer.sv
